/* bench/sd_card_model.sv */
// behavioral SD card in SPI mode
// frame decoder, init command answers, one data block per CMD17
`timescale 1ns/10ps

module sd_card_model import sd_host_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        sclk_i,
   input  logic        ss_i,
   input  logic        mosi_i,
   input  logic        ccs_i,
   output logic        miso_o,
   output int          frame_count_o,
   output int          cmd55_count_o,
   output logic [5:0]  last_opcode_o,
   output logic [31:0] last_arg_o,
   output logic [7:0]  last_crc_o
);

   logic       miso_q = 1'b1;
   logic       sclk_q;
   logic [7:0] rx_sr;
   logic [7:0] tx_sr;
   int         bit_cnt;
   int         frame_idx;
   int         acmd41_count;
   logic [7:0] frame [6];
   logic [7:0] tx_q[$];

   assign miso_o = miso_q;

   // block contents, same rule the bench checks against
   function automatic logic [7:0] block_byte(input logic [31:0] addr, input int idx);
      logic [31:0] sum;
      sum = addr + 32'(idx) * 32'd7;
      return 8'(sum ^ 32'(idx));
   endfunction

   task automatic answer_command(input logic [5:0] op, input logic [31:0] arg);
      int i;
      case (op)
         CMD0:
            tx_q.push_back(R1_IDLE);
         CMD8:
         begin
            // echo of the voltage check pattern
            tx_q.push_back(R1_IDLE);
            tx_q.push_back(8'h00);
            tx_q.push_back(8'h00);
            tx_q.push_back(8'h01);
            tx_q.push_back(8'hAA);
         end
         CMD55:
         begin
            tx_q.push_back(R1_IDLE);
            cmd55_count_o <= cmd55_count_o + 1;
         end
         ACMD41:
         begin
            // still powering up for the first three tries
            tx_q.push_back((acmd41_count < 3) ? R1_IDLE : R1_READY);
            acmd41_count++;
         end
         CMD58:
         begin
            tx_q.push_back(R1_READY);
            tx_q.push_back({1'b1, ccs_i, 6'b0});
            tx_q.push_back(8'hFF);
            tx_q.push_back(8'h80);
            tx_q.push_back(8'h00);
         end
         CMD17:
         begin
            tx_q.push_back(R1_READY);
            repeat (3) tx_q.push_back(FILL_BYTE);
            tx_q.push_back(START_TOKEN);
            for (i = 0; i < BLOCK_BYTES; i++)
               tx_q.push_back(block_byte(arg, i));
            tx_q.push_back(8'hA5);
            tx_q.push_back(8'h5A);
         end
         // illegal command
         default:
            tx_q.push_back(8'h04);
      endcase
   endtask

   task automatic take_byte(input logic [7:0] b);
      if (frame_idx > 0 || b[7:6] == 2'b01)
      begin
         frame[frame_idx] = b;
         frame_idx++;
         if (frame_idx == 6)
         begin
            frame_idx = 0;
            answer_command(frame[0][5:0], {frame[1], frame[2], frame[3], frame[4]});
            last_opcode_o <= frame[0][5:0];
            last_arg_o    <= {frame[1], frame[2], frame[3], frame[4]};
            last_crc_o    <= frame[5];
            frame_count_o <= frame_count_o + 1;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // SPI mode 0 slave, sclk sampled on the falling clk edge
   ////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (reset)
      begin
         miso_q        <= 1'b1;
         frame_count_o <= 0;
         cmd55_count_o <= 0;
         bit_cnt       = 0;
         frame_idx     = 0;
         acmd41_count  = 0;
         tx_sr         = FILL_BYTE;
         tx_q.delete();
      end
      else if (ss_i)
      begin
         bit_cnt = 0;
         miso_q <= 1'b1;
      end
      else if (sclk_i && !sclk_q)
      begin
         rx_sr = {rx_sr[6:0], mosi_i};
         bit_cnt++;
         if (bit_cnt == 8)
            take_byte(rx_sr);
      end
      else if (!sclk_i && sclk_q)
      begin
         // next byte goes out after the last falling edge
         if (bit_cnt == 8)
         begin
            bit_cnt = 0;
            tx_sr = (tx_q.size() > 0) ? tx_q.pop_front() : FILL_BYTE;
         end
         else
            tx_sr = {tx_sr[6:0], 1'b1};
         miso_q <= tx_sr[7];
      end
      sclk_q = sclk_i;
   end

endmodule

/* bench/tb_sd_host.sv */
// testbench for the SD card SPI host
// clock, reset, init frame checks, block reads with back-pressure
// reference byte function and data compare process
`timescale 1ns/10ps

module tb_sd_host import sd_host_pkg::*; ();

   localparam int POWER_UP_CYCLES = 200;
   localparam int SCLK_DIV        = 2;
   localparam int INIT_FRAMES     = 11;
   localparam int READS           = 3;

   logic        clk;
   logic        reset;
   logic        read_block_i;
   logic [31:0] block_addr_i;
   logic        read_byte_i;
   logic        busy_o;
   logic        err_o;
   logic [7:0]  data_o;
   logic        miso;
   logic        mosi;
   logic        sclk;
   logic        ss;
   logic        ccs;

   int          frame_count;
   int          cmd55_count;
   logic [5:0]  last_opcode;
   logic [31:0] last_arg;
   logic [7:0]  last_crc;

   logic [5:0]  op_log[$];
   logic [31:0] arg_log[$];
   logic [7:0]  crc_log[$];
   int          seen_frames;

   logic        rd_active;
   logic [31:0] cur_addr;
   int          rd_count;
   logic        busy_q;
   logic [31:0] rnd;

   sd_host_top #(.POWER_UP_CYCLES(POWER_UP_CYCLES), .SCLK_DIV(SCLK_DIV)) dut0
   (
      .clk          (clk),
      .reset        (reset),
      .read_block_i (read_block_i),
      .block_addr_i (block_addr_i),
      .read_byte_i  (read_byte_i),
      .busy_o       (busy_o),
      .err_o        (err_o),
      .data_o       (data_o),
      .miso_i       (miso),
      .mosi_o       (mosi),
      .sclk_o       (sclk),
      .ss_o         (ss)
   );

   sd_card_model card0
   (
      .clk           (clk),
      .reset         (reset),
      .sclk_i        (sclk),
      .ss_i          (ss),
      .mosi_i        (mosi),
      .ccs_i         (ccs),
      .miso_o        (miso),
      .frame_count_o (frame_count),
      .cmd55_count_o (cmd55_count),
      .last_opcode_o (last_opcode),
      .last_arg_o    (last_arg),
      .last_crc_o    (last_crc)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [7:0] expected_byte(input logic [31:0] addr, input int idx);
      logic [31:0] sum;
      sum = addr + 32'(idx) * 32'd7;
      return 8'(sum ^ 32'(idx));
   endfunction

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout at %0t ns while waiting for %s", $time, what);
      $display("Test failed");
      $fatal(1, "stopped on timeout");
   endtask

   // wait for busy_o low or err_o high
   task automatic wait_settled(input int limit, input string what);
      int n;
      n = 0;
      while (busy_o && !err_o && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (busy_o && !err_o)
         timeout_fail(what);
   endtask

   task automatic check_frame(input int idx, input sd_cmd_e op, input logic [31:0] arg,
                              input logic [7:0] crc);
      check_value($sformatf("opcode of frame %0d", idx), 32'(op_log[idx]), 32'(op));
      check_value($sformatf("argument of frame %0d", idx), arg_log[idx], arg);
      check_value($sformatf("crc of frame %0d", idx), 32'(crc_log[idx]), 32'(crc));
   endtask

   task automatic read_block(input logic [31:0] addr, input logic stall);
      int i;
      int g;
      int gap;
      block_addr_i <= addr;
      cur_addr     <= addr;
      rd_active    <= 1'b1;
      read_block_i <= 1'b1;
      @(negedge clk);
      for (i = 0; i < BLOCK_BYTES; i++)
      begin
         wait_settled(2000, "data byte");
         check_value("error during read", 32'(err_o), 0);
         gap = 0;
         if (stall)
         begin
            rnd = lcg_next(rnd);
            gap = int'(rnd[10:8]);
         end
         // host has to hold with sclk stopped
         for (g = 0; g < gap; g++)
         begin
            check_value("sclk while held off", 32'(sclk), 0);
            @(negedge clk);
         end
         read_byte_i <= 1'b1;
         if (i == BLOCK_BYTES - 1)
            read_block_i <= 1'b0;
         @(negedge clk);
         read_byte_i <= 1'b0;
      end
      wait_settled(1000, "idle after read");
      check_value("error after read", 32'(err_o), 0);
      check_value("bytes compared", rd_count, BLOCK_BYTES);
      rd_active <= 1'b0;
      @(negedge clk);
   endtask

   ////////////////////////////////////////////////////////////
   // frame log and data compare
   ////////////////////////////////////////////////////////////

   always @(negedge clk)
   begin
      if (reset)
      begin
         seen_frames = 0;
         op_log.delete();
         arg_log.delete();
         crc_log.delete();
      end
      else if (frame_count != seen_frames)
      begin
         seen_frames = frame_count;
         op_log.push_back(last_opcode);
         arg_log.push_back(last_arg);
         crc_log.push_back(last_crc);
      end
   end

   // each fall of busy_o during a read presents the next byte
   always @(negedge clk)
   begin
      if (!rd_active)
         rd_count <= 0;
      else if (busy_q && !busy_o && rd_count < BLOCK_BYTES)
      begin
         check_value($sformatf("data byte %0d", rd_count), 32'(data_o),
                     32'(expected_byte(cur_addr, rd_count)));
         rd_count <= rd_count + 1;
      end
      busy_q <= busy_o;
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   initial
   begin
      int r;
      int k;
      logic [31:0] addr;
      reset        <= 1'b1;
      read_block_i <= 1'b0;
      block_addr_i <= '0;
      read_byte_i  <= 1'b0;
      ccs          <= 1'b0;
      rd_active    <= 1'b0;
      cur_addr     <= '0;
      rnd = 32'hbbb4;
      repeat (10) @(negedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("busy after reset", 32'(busy_o), 1);
      check_value("error after reset", 32'(err_o), 0);
      check_value("ss after reset", 32'(ss), 1);
      check_value("sclk after reset", 32'(sclk), 0);
      check_value("mosi after reset", 32'(mosi), 1);

      wait_settled(20000, "end of initialization");
      check_value("error after init", 32'(err_o), 0);
      check_value("frames during init", op_log.size(), INIT_FRAMES);
      check_frame(0, CMD0, 32'h0, CMD0_CRC);
      check_frame(1, CMD8, CMD8_ARG, CMD8_CRC);
      for (k = 0; k < 4; k++)
      begin
         check_frame(2 + 2 * k, CMD55, 32'h0, DUMMY_CRC);
         check_frame(3 + 2 * k, ACMD41, ACMD41_ARG, DUMMY_CRC);
      end
      check_frame(10, CMD58, 32'h0, DUMMY_CRC);
      check_value("CMD55 count", cmd55_count, 4);

      // last read runs with random hold-off gaps
      for (r = 0; r < READS; r++)
      begin
         rnd = lcg_next(rnd);
         addr = rnd;
         read_block(addr, r == READS - 1);
         check_value("frames after read", op_log.size(), INIT_FRAMES + r + 1);
         check_frame(INIT_FRAMES + r, CMD17, addr, DUMMY_CRC);
      end

      // power up again, this time with a high capacity card
      ccs   <= 1'b1;
      reset <= 1'b1;
      repeat (10) @(negedge clk);
      reset <= 1'b0;
      @(negedge clk);
      wait_settled(20000, "error on high capacity card");
      check_value("error flag", 32'(err_o), 1);
      check_value("busy with error", 32'(busy_o), 1);
      check_value("frames before error", op_log.size(), INIT_FRAMES);
      check_frame(INIT_FRAMES - 1, CMD58, 32'h0, DUMMY_CRC);
      repeat (20) @(negedge clk);
      check_value("error stays set", 32'(err_o), 1);
      check_value("busy stays set", 32'(busy_o), 1);

      $display("Test completed successfully");
      $finish;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# build the SD host testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sd_host -Mdir obj_dir -f sim.f \
   || { echo "build failed"; exit 1; }
./obj_dir/Vtb_sd_host > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"

/* sim.f */
verilog/sd_host_pkg.sv
verilog/spi_byte_if.sv
verilog/sd_cmd_if.sv
verilog/spi_byte_shifter.sv
verilog/sd_cmd_engine.sv
verilog/sd_card_sequencer.sv
verilog/sd_host_top.sv
bench/sd_card_model.sv
bench/tb_sd_host.sv

/* verilog/sd_card_sequencer.sv */
// card power-up, initialization and single-block read FSM
// also selects who drives the SPI shifter
`timescale 1ns/10ps

module sd_card_sequencer import sd_host_pkg::*;
#(parameter int POWER_UP_CYCLES = 25000000)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        read_block_i,
   input  logic [31:0] block_addr_i,
   input  logic        read_byte_i,
   output logic        busy_o,
   output logic        err_o,
   output logic        ss_o,
   sd_cmd_if.issuer    cmd,
   spi_byte_if.shifter spi_cmd,
   spi_byte_if.master  spi_phy
);

   seq_state_e  state;
   seq_state_e  ret_state;
   logic [31:0] count;
   logic        ss_q;
   logic        seq_start;
   logic [7:0]  r1;

   assign r1 = cmd.response[39:32];

   ////////////////////////////////////////////////////////////
   // SPI path selection
   ////////////////////////////////////////////////////////////

   // command engine owns the shifter only while a command runs
   always_comb
   begin
      if (state == S_CMD_WAIT)
      begin
         spi_phy.start   = spi_cmd.start;
         spi_phy.tx_byte = spi_cmd.tx_byte;
      end
      else
      begin
         spi_phy.start   = seq_start;
         spi_phy.tx_byte = FILL_BYTE;
      end
   end

   assign spi_cmd.rx_byte = spi_phy.rx_byte;
   assign spi_cmd.busy    = spi_phy.busy;

   // byte requests and command fields per state
   always_comb
   begin
      seq_start    = 1'b0;
      cmd.start    = 1'b0;
      cmd.opcode   = CMD0;
      cmd.argument = 32'h0;
      cmd.crc      = DUMMY_CRC;
      case (state)
         S_FILL:       seq_start = (count != FILL_BYTES);
         S_TOKEN_WAIT: seq_start = (spi_phy.rx_byte != START_TOKEN);
         S_BYTE_WAIT:  seq_start = 1'b1;
         S_CRC_SKIP:   seq_start = (count != CRC_BYTES);
         S_CMD0:
         begin
            cmd.start = 1'b1;
            cmd.crc   = CMD0_CRC;
         end
         S_CMD8:
         begin
            cmd.start    = 1'b1;
            cmd.opcode   = CMD8;
            cmd.argument = CMD8_ARG;
            cmd.crc      = CMD8_CRC;
         end
         S_CMD55:
         begin
            cmd.start  = 1'b1;
            cmd.opcode = CMD55;
         end
         S_ACMD41:
         begin
            cmd.start    = 1'b1;
            cmd.opcode   = ACMD41;
            cmd.argument = ACMD41_ARG;
         end
         S_CMD58:
         begin
            cmd.start  = 1'b1;
            cmd.opcode = CMD58;
         end
         S_CMD17:
         begin
            cmd.start    = 1'b1;
            cmd.opcode   = CMD17;
            cmd.argument = block_addr_i;
         end
         default: ;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // main FSM
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= S_POWER_UP;
         ret_state <= S_POWER_UP;
         count     <= '0;
         ss_q      <= 1'b1;
      end
      else
      begin
         // any wait state returns here
         if (seq_start || cmd.start)
            ret_state <= state;

         case (state)
            S_POWER_UP:
            begin
               ss_q  <= 1'b1;
               count <= count + 32'd1;
               if (count == 32'(POWER_UP_CYCLES - 1))
               begin
                  count <= '0;
                  state <= S_FILL;
               end
            end
            S_FILL:
               if (seq_start)
               begin
                  count <= count + 32'd1;
                  state <= S_SPI_WAIT;
               end
               else
               begin
                  // ss still high means this was the power-up fill
                  count <= '0;
                  ss_q  <= 1'b0;
                  state <= ss_q ? S_CMD0 : S_CMD17;
               end
            S_CMD0, S_CMD8, S_CMD55, S_ACMD41, S_CMD58, S_CMD17:
               state <= S_CMD_WAIT;
            S_CMD0_CHK:
            begin
               count <= '0;
               state <= (r1 == R1_IDLE) ? S_CMD8 : S_POWER_UP;
            end
            S_CMD8_CHK:
            begin
               count <= '0;
               state <= (r1 == R1_IDLE) ? S_CMD55 : S_ERROR;
            end
            S_CMD55_CHK:
               state <= (r1 == R1_IDLE) ? S_ACMD41 : S_ERROR;
            S_ACMD41_CHK:
               if (r1 == R1_READY)
                  state <= S_CMD58;
               else if (count == 32'(ACMD41_MAX_TRIES - 1))
                  state <= S_ERROR;
               else
               begin
                  count <= count + 32'd1;
                  state <= S_CMD55;
               end
            // high capacity cards are not supported
            S_CMD58_CHK:
               state <= cmd.response[OCR_CCS_BIT] ? S_ERROR : S_IDLE;
            S_IDLE:
            begin
               count <= '0;
               if (read_block_i)
                  state <= S_FILL;
            end
            S_CMD17_CHK:
               state <= (r1 == R1_READY) ? S_TOKEN_WAIT : S_ERROR;
            S_TOKEN_WAIT:
               if (seq_start)
                  state <= S_SPI_WAIT;
               else
               begin
                  count <= '0;
                  state <= S_BYTE_WAIT;
               end
            S_BYTE_WAIT:
            begin
               count <= count + 32'd1;
               state <= S_SPI_WAIT;
            end
            S_BYTE_READY:
               if (read_byte_i)
               begin
                  if (count == BLOCK_BYTES)
                  begin
                     count <= '0;
                     state <= S_CRC_SKIP;
                  end
                  else
                     state <= S_BYTE_WAIT;
               end
            S_CRC_SKIP:
               if (seq_start)
               begin
                  count <= count + 32'd1;
                  state <= S_SPI_WAIT;
               end
               else
                  state <= S_IDLE;
            S_SPI_WAIT:
               if (!spi_phy.busy)
                  state <= (ret_state == S_BYTE_WAIT) ? S_BYTE_READY : ret_state;
            // go on to the check state after the issue state
            S_CMD_WAIT:
               if (!cmd.busy)
                  state <= seq_state_e'(ret_state + 5'd1);
            S_ERROR: ;
            default:
               state <= S_ERROR;
         endcase
      end
   end

   assign busy_o = !(state == S_IDLE || state == S_BYTE_READY);
   assign err_o  = (state == S_ERROR);
   assign ss_o   = ss_q;

   // error is terminal and keeps the host busy
   err_sticky: assert property (@(posedge clk) disable iff (reset)
      err_o |=> err_o && busy_o);

endmodule

/* verilog/sd_cmd_engine.sv */
// command engine: 6-byte frame out, R1 poll, 4 trailing bytes in
`timescale 1ns/10ps

module sd_cmd_engine import sd_host_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   sd_cmd_if.engine  cmd,
   spi_byte_if.master spi
);

   cmd_state_e  state;
   logic [47:0] frame;
   logic [2:0]  byte_cnt;
   logic        pending;
   logic        byte_done;
   logic        poll_last;
   logic        r1_seen;

   assign cmd.busy    = (state != C_IDLE);
   assign spi.start   = (state != C_IDLE) && !pending;
   assign spi.tx_byte = (state == C_SEND) ? frame[47:40] : FILL_BYTE;
   assign byte_done   = pending && !spi.busy;
   assign poll_last   = (byte_cnt == 3'(RESP_POLL_LIMIT - 1));
   assign r1_seen     = byte_done && !spi.rx_byte[7];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= C_IDLE;
         pending  <= 1'b0;
         byte_cnt <= '0;
      end
      else
      begin
         if (spi.start)
            pending <= 1'b1;
         else if (byte_done)
            pending <= 1'b0;

         case (state)
            C_IDLE:
               if (cmd.start)
               begin
                  byte_cnt <= '0;
                  state    <= C_SEND;
               end
            C_SEND:
               if (byte_done)
               begin
                  byte_cnt <= (byte_cnt == 3'd5) ? 3'd0 : byte_cnt + 3'd1;
                  if (byte_cnt == 3'd5)
                     state <= C_POLL;
               end
            C_POLL:
               if (r1_seen)
               begin
                  byte_cnt <= '0;
                  state    <= C_COLLECT;
               end
               else if (byte_done)
               begin
                  byte_cnt <= byte_cnt + 3'd1;
                  // card never answered
                  if (poll_last)
                     state <= C_IDLE;
               end
            C_COLLECT:
               if (byte_done)
               begin
                  byte_cnt <= byte_cnt + 3'd1;
                  if (byte_cnt == 3'd3)
                     state <= C_IDLE;
               end
            default:
               state <= C_IDLE;
         endcase
      end
   end

   // frame and response payload
   always_ff @(posedge clk)
   begin
      if (state == C_IDLE && cmd.start)
         frame <= {2'b01, cmd.opcode, cmd.argument, cmd.crc};
      else if (state == C_SEND && byte_done)
         frame <= {frame[39:0], FILL_BYTE};

      if (state == C_POLL && r1_seen)
         cmd.response[39:32] <= spi.rx_byte;
      else if (state == C_POLL && byte_done && poll_last)
         cmd.response[39:32] <= FILL_BYTE;
      else if (state == C_COLLECT && byte_done)
         cmd.response[31:0] <= {cmd.response[23:0], spi.rx_byte};
   end

   // sequencer may only issue while the previous command has finished
   issue_when_idle: assert property (@(posedge clk) disable iff (reset)
      cmd.start |-> !cmd.busy);

endmodule

/* verilog/sd_cmd_if.sv */
// command request and response between sequencer and command engine
`timescale 1ns/10ps

interface sd_cmd_if import sd_host_pkg::*; ();

   logic        start;
   sd_cmd_e     opcode;
   logic [31:0] argument;
   logic [7:0]  crc;
   logic        busy;
   // R1 in the top byte, trailing bytes below
   logic [39:0] response;

   modport issuer (output start, opcode, argument, crc, input busy, response);
   modport engine (input start, opcode, argument, crc, output busy, response);

endinterface

/* verilog/sd_host_pkg.sv */
// shared constants and types for the SD card SPI host
// command indexes, FSM state enums, protocol bytes
package sd_host_pkg;

   // command indexes as sent in the frame
   typedef enum logic [5:0] {
      CMD0   = 6'd0,
      CMD8   = 6'd8,
      CMD17  = 6'd17,
      ACMD41 = 6'd41,
      CMD55  = 6'd55,
      CMD58  = 6'd58
   } sd_cmd_e;

   // each command issue state is directly followed by its check state
   typedef enum logic [4:0] {
      S_POWER_UP, S_FILL,
      S_CMD0, S_CMD0_CHK, S_CMD8, S_CMD8_CHK,
      S_CMD55, S_CMD55_CHK, S_ACMD41, S_ACMD41_CHK,
      S_CMD58, S_CMD58_CHK, S_IDLE, S_CMD17, S_CMD17_CHK,
      S_TOKEN_WAIT, S_BYTE_WAIT, S_BYTE_READY, S_CRC_SKIP,
      S_SPI_WAIT, S_CMD_WAIT, S_ERROR
   } seq_state_e;

   typedef enum logic [1:0] {C_IDLE, C_SEND, C_POLL, C_COLLECT} cmd_state_e;

   localparam int BLOCK_BYTES      = 512;
   localparam int CRC_BYTES        = 2;
   localparam int OCR_CCS_BIT      = 30;
   localparam int ACMD41_MAX_TRIES = 255;
   localparam int RESP_POLL_LIMIT  = 8;
   localparam int FILL_BYTES       = 10;

   localparam logic [7:0]  FILL_BYTE   = 8'hFF;
   localparam logic [7:0]  START_TOKEN = 8'hFE;
   localparam logic [7:0]  R1_IDLE     = 8'h01;
   localparam logic [7:0]  R1_READY    = 8'h00;
   localparam logic [7:0]  CMD0_CRC    = 8'h95;
   localparam logic [7:0]  CMD8_CRC    = 8'h87;
   localparam logic [7:0]  DUMMY_CRC   = 8'h01;
   localparam logic [31:0] CMD8_ARG    = 32'h0000_01AA;
   localparam logic [31:0] ACMD41_ARG  = 32'h4000_0000;

endpackage

/* verilog/sd_host_top.sv */
// SD card SPI-mode host, top level
// sequencer, command engine and byte shifter
`timescale 1ns/10ps

module sd_host_top
#(
   parameter int POWER_UP_CYCLES = 25000000,
   parameter int SCLK_DIV        = 4
)
(
   input  logic        clk,
   input  logic        reset,
   input  logic        read_block_i,
   input  logic [31:0] block_addr_i,
   input  logic        read_byte_i,
   output logic        busy_o,
   output logic        err_o,
   output logic [7:0]  data_o,
   input  logic        miso_i,
   output logic        mosi_o,
   output logic        sclk_o,
   output logic        ss_o
);

   sd_cmd_if   cmd ();
   spi_byte_if spi_cmd ();
   spi_byte_if spi_phy ();

   sd_card_sequencer #(.POWER_UP_CYCLES(POWER_UP_CYCLES)) seq0
   (
      .clk          (clk),
      .reset        (reset),
      .read_block_i (read_block_i),
      .block_addr_i (block_addr_i),
      .read_byte_i  (read_byte_i),
      .busy_o       (busy_o),
      .err_o        (err_o),
      .ss_o         (ss_o),
      .cmd          (cmd.issuer),
      .spi_cmd      (spi_cmd.shifter),
      .spi_phy      (spi_phy.master)
   );

   sd_cmd_engine cmd0
   (
      .clk   (clk),
      .reset (reset),
      .cmd   (cmd.engine),
      .spi   (spi_cmd.master)
   );

   spi_byte_shifter #(.SCLK_DIV(SCLK_DIV)) spi0
   (
      .clk    (clk),
      .reset  (reset),
      .spi    (spi_phy.shifter),
      .miso_i (miso_i),
      .mosi_o (mosi_o),
      .sclk_o (sclk_o)
   );

   // read data comes straight from the shifter
   assign data_o = spi_phy.rx_byte;

endmodule

/* verilog/spi_byte_if.sv */
// one SPI byte transfer, request and result
`timescale 1ns/10ps

interface spi_byte_if;

   logic       start;
   logic [7:0] tx_byte;
   logic [7:0] rx_byte;
   logic       busy;

   modport master
   (
      output start, tx_byte,
      input  rx_byte, busy
   );

   modport shifter
   (
      input  start, tx_byte,
      output rx_byte, busy
   );

endinterface

/* verilog/spi_byte_shifter.sv */
// SPI mode 0 byte shifter with fixed sclk divider
`timescale 1ns/10ps

module spi_byte_shifter #(parameter int SCLK_DIV = 4)
(
   input  logic       clk,
   input  logic       reset,
   spi_byte_if.shifter spi,
   input  logic       miso_i,
   output logic       mosi_o,
   output logic       sclk_o
);

   localparam int DIV_W = $clog2(SCLK_DIV + 1);

   logic [DIV_W-1:0] div_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       tx_shift;
   logic [7:0]       rx_shift;
   logic             busy_q;
   logic             half_tick;
   logic             load;

   assign load      = spi.start && !busy_q;
   assign half_tick = busy_q && (div_cnt == DIV_W'(SCLK_DIV - 1));

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_q  <= 1'b0;
         sclk_o  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end
      else if (load)
      begin
         busy_q  <= 1'b1;
         sclk_o  <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
      end
      else if (half_tick)
      begin
         div_cnt <= '0;
         sclk_o  <= !sclk_o;
         // falling edge closes a bit
         if (sclk_o)
         begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
               busy_q <= 1'b0;
         end
      end
      else if (busy_q)
         div_cnt <= div_cnt + 1'b1;
   end

   // sample on rising sclk, shift out on falling sclk
   always_ff @(posedge clk)
   begin
      if (load)
         tx_shift <= spi.tx_byte;
      else if (half_tick && sclk_o)
         tx_shift <= {tx_shift[6:0], 1'b1};
      if (half_tick && !sclk_o)
         rx_shift <= {rx_shift[6:0], miso_i};
   end

   assign mosi_o      = busy_q ? tx_shift[7] : 1'b1;
   assign spi.busy    = busy_q;
   assign spi.rx_byte = rx_shift;

   // the master has to wait for the previous byte
   start_while_idle: assert property (@(posedge clk) disable iff (reset)
      spi.start |-> !busy_q);

endmodule
